/* hw/cpuIsaPkg.sv */
package cpuIsaPkg;

	localparam int wordWidth = 32;	// bus and register width
	localparam int addrWidth = 9;	// 512 words of memory
	localparam int regCount = 16;
	localparam int regIdxWidth = 4;
	localparam int opcodeWidth = 5;
	localparam int immWidth = 19;	// C field, sign extended

	// low bit of each instruction field
	localparam int opcodePos = 27;	// bits 31..27
	localparam int raPos = 23;	// bits 26..23
	localparam int rbPos = 19;	// bits 22..19
	localparam int rcPos = 15;	// bits 18..15
	localparam int immPos = 0;	// bits 18..0, overlaps rc

	typedef enum logic [opcodeWidth-1:0] {
		opLd = 5'b00000,
		opSt = 5'b00010,
		opAddi = 5'b01100,
		opHalt = 5'b11011
	} opcode_t;

endpackage

/* hw/cpuControlPkg.sv */
package cpuControlPkg;

	typedef enum logic [3:0] {
		phIdle,
		phT0, phT1, phT2, phT3, phT4,
		phT5, phT6, phT7, phT8, phT9,
		phHalt
	} phase_t;

	typedef enum logic [2:0] {
		srcPc,
		srcZLow,
		srcMdr,
		srcReg,
		srcImm,
		srcNone
	} busSource_t;

	typedef enum logic {
		aluAdd,	// Y + bus
		aluIncPc	// bus + 1
	} aluOp_t;

	typedef enum logic [1:0] {
		selA,
		selB,
		selC
	} regSelect_t;

	typedef struct packed {
		busSource_t busSrc;
		logic pcIn;
		logic irIn;
		logic marIn;
		logic mdrIn;
		logic yIn;
		logic zIn;
		logic mdRead;	// MDR takes memory data instead of bus
		logic regIn;
		regSelect_t regSelect;
		logic baOut;	// r0 reads as zero
		aluOp_t aluOp;
		logic ramRead;
		logic ramWrite;
	} controlWord_t;

	// nothing strobed, bus undriven
	localparam controlWord_t cwNop = '{
		busSrc: srcNone,
		pcIn: 1'b0,
		irIn: 1'b0,
		marIn: 1'b0,
		mdrIn: 1'b0,
		yIn: 1'b0,
		zIn: 1'b0,
		mdRead: 1'b0,
		regIn: 1'b0,
		regSelect: selA,
		baOut: 1'b0,
		aluOp: aluAdd,
		ramRead: 1'b0,
		ramWrite: 1'b0
	};

endpackage

/* hw/cpuInterfaces.sv */
interface controlIf;
	import cpuIsaPkg::*;
	import cpuControlPkg::*;

	controlWord_t cw;	// one control word per cycle
	logic [wordWidth-1:0] ir;	// decoded by the sequencer

	modport sequencer (
		output cw,
		input ir
	);

	modport datapath (
		input cw,
		output ir
	);
endinterface

interface memoryIf;
	import cpuIsaPkg::*;

	logic [addrWidth-1:0] address;
	logic [wordWidth-1:0] writeData;
	logic [wordWidth-1:0] readData;	// valid the cycle after read
	logic read;
	logic write;

	modport master (
		output address,
		output writeData,
		output read,
		output write,
		input readData
	);

	modport memory (
		input address,
		input writeData,
		input read,
		input write,
		output readData
	);
endinterface

/* hw/controlSequencer.sv */
module controlSequencer (
	input logic clk,
	input logic reset,
	input logic start,
	controlIf.sequencer ctrl,
	output logic busy,
	output logic done
);
	import cpuIsaPkg::*;
	import cpuControlPkg::*;

	phase_t phase;
	phase_t nextPhase;
	opcode_t opcode;
	logic isKnown;
	controlWord_t cw;

	assign opcode = opcode_t'(ctrl.ir[opcodePos +: opcodeWidth]);
	assign isKnown = (opcode == opAddi) || (opcode == opLd) || (opcode == opSt);

	always_ff @(posedge clk) begin
		if (reset)
			phase <= phIdle;
		else
			phase <= nextPhase;
	end

	always_comb begin
		nextPhase = phase;
		case (phase)
			phIdle: begin
				if (start)
					nextPhase = phT0;
			end
			phT0: nextPhase = phT1;
			phT1: nextPhase = phT2;
			phT2: nextPhase = phT3;
			phT3: nextPhase = phT4;
			phT4: nextPhase = isKnown ? phT5 : phHalt;	// halt or bad opcode stops here
			phT5: nextPhase = phT6;
			phT6: nextPhase = (opcode == opAddi) ? phT0 : phT7;
			phT7: nextPhase = (opcode == opSt) ? phT0 : phT8;
			phT8: nextPhase = phT9;
			phT9: nextPhase = phT0;
			default: nextPhase = phIdle;	// phHalt lasts one cycle
		endcase
	end

	always_comb begin
		cw = cwNop;
		case (phase)
			phT0: begin
				cw.busSrc = srcPc;
				cw.marIn = 1'b1;
				cw.aluOp = aluIncPc;
				cw.zIn = 1'b1;
			end
			phT1: begin
				cw.busSrc = srcZLow;
				cw.pcIn = 1'b1;
				cw.ramRead = 1'b1;	// fetch at old PC held in MAR
			end
			phT2: begin
				cw.mdrIn = 1'b1;
				cw.mdRead = 1'b1;
			end
			phT3: begin
				cw.busSrc = srcMdr;
				cw.irIn = 1'b1;
			end
			phT4: begin
				if (isKnown) begin
					cw.busSrc = srcReg;
					cw.regSelect = selB;
					cw.baOut = 1'b1;	// rb = r0 gives plain C
					cw.yIn = 1'b1;
				end
			end
			phT5: begin
				cw.busSrc = srcImm;
				cw.aluOp = aluAdd;
				cw.zIn = 1'b1;
			end
			phT6: begin
				cw.busSrc = srcZLow;
				if (opcode == opAddi) begin
					cw.regSelect = selA;
					cw.regIn = 1'b1;
				end else begin
					cw.marIn = 1'b1;	// effective address
				end
			end
			phT7: begin
				if (opcode == opSt) begin
					cw.busSrc = srcReg;
					cw.regSelect = selA;
					cw.ramWrite = 1'b1;
				end else begin
					cw.ramRead = 1'b1;
				end
			end
			phT8: begin
				cw.mdrIn = 1'b1;
				cw.mdRead = 1'b1;
			end
			phT9: begin
				cw.busSrc = srcMdr;
				cw.regSelect = selA;
				cw.regIn = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign ctrl.cw = cw;
	assign busy = (phase != phIdle) && (phase != phHalt);
	assign done = (phase == phHalt);

	assert property (@(posedge clk) disable iff (reset) !(cw.ramRead && cw.ramWrite));
	assert property (@(posedge clk) disable iff (reset) done |=> !done);

endmodule

/* hw/registerFile.sv */
module registerFile (
	input logic clk,
	input logic reset,
	input logic [cpuIsaPkg::regIdxWidth-1:0] index,
	input logic [cpuIsaPkg::wordWidth-1:0] writeData,
	input logic write,
	input logic baOut,
	output logic [cpuIsaPkg::wordWidth-1:0] readData,
	input logic [cpuIsaPkg::regIdxWidth-1:0] hostIndex,
	output logic [cpuIsaPkg::wordWidth-1:0] hostData
);
	import cpuIsaPkg::*;

	logic [wordWidth-1:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (write) begin
			regs[index] <= writeData;
		end
	end

	// r0 is a real register, masked only under BAout
	assign readData = (baOut && index == '0) ? '0 : regs[index];
	assign hostData = regs[hostIndex];	// host view while idle

	assert property (@(posedge clk) disable iff (reset) write |-> !$isunknown(index));

endmodule

/* hw/busDatapath.sv */
module busDatapath (
	input logic clk,
	input logic reset,
	controlIf.datapath ctrl,
	memoryIf.master mem,
	input logic [cpuIsaPkg::wordWidth-1:0] startPc,
	input logic start,
	output logic [cpuIsaPkg::regIdxWidth-1:0] regIndex,
	output logic [cpuIsaPkg::wordWidth-1:0] regWriteData,
	output logic regWrite,
	output logic regBaOut,
	input logic [cpuIsaPkg::wordWidth-1:0] regReadData,
	output logic [cpuIsaPkg::wordWidth-1:0] pc
);
	import cpuIsaPkg::*;
	import cpuControlPkg::*;

	controlWord_t cw;
	logic [wordWidth-1:0] pcReg;
	logic [wordWidth-1:0] ir;
	logic [addrWidth-1:0] mar;
	logic [wordWidth-1:0] mdr;
	logic [wordWidth-1:0] y;
	logic [wordWidth-1:0] z;
	logic [wordWidth-1:0] bus;
	logic [wordWidth-1:0] immExt;
	logic [wordWidth-1:0] aluResult;
	logic busLoad;

	assign cw = ctrl.cw;
	assign immExt = {{(wordWidth - immWidth){ir[immPos + immWidth - 1]}}, ir[immPos +: immWidth]};

	always_comb begin
		case (cw.busSrc)
			srcPc: bus = pcReg;
			srcZLow: bus = z;
			srcMdr: bus = mdr;
			srcReg: bus = regReadData;
			srcImm: bus = immExt;
			default: bus = '0;	// srcNone
		endcase
	end

	assign aluResult = (cw.aluOp == aluIncPc) ? bus + 1'b1 : y + bus;

	// Gra/Grb/Grc resolved from the IR fields
	always_comb begin
		case (cw.regSelect)
			selA: regIndex = ir[raPos +: regIdxWidth];
			selB: regIndex = ir[rbPos +: regIdxWidth];
			default: regIndex = ir[rcPos +: regIdxWidth];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pcReg <= '0;
			ir <= '0;
		end else begin
			if (start)
				pcReg <= startPc;
			else if (cw.pcIn)
				pcReg <= bus;
			if (cw.irIn)
				ir <= bus;
		end
	end

	always_ff @(posedge clk) begin
		if (cw.marIn)
			mar <= bus[addrWidth-1:0];	// upper bus bits unused
		if (cw.mdrIn)
			mdr <= cw.mdRead ? mem.readData : bus;
		if (cw.yIn)
			y <= bus;
		if (cw.zIn)
			z <= aluResult;
	end

	assign regWriteData = bus;
	assign regWrite = cw.regIn;
	assign regBaOut = cw.baOut;

	assign mem.address = mar;
	assign mem.writeData = regReadData;	// ra via Gra during st
	assign mem.read = cw.ramRead;
	assign mem.write = cw.ramWrite;

	assign ctrl.ir = ir;
	assign pc = pcReg;

	assign busLoad = cw.pcIn || cw.irIn || cw.marIn || cw.yIn || cw.zIn || cw.regIn ||
		(cw.mdrIn && !cw.mdRead);

	assert property (@(posedge clk) disable iff (reset) busLoad |-> cw.busSrc != srcNone);

endmodule

/* hw/dataMemory.sv */
module dataMemory (
	input logic clk,
	memoryIf.memory mem,
	input logic hostWrite,
	input logic [cpuIsaPkg::addrWidth-1:0] hostAddress,
	input logic [cpuIsaPkg::wordWidth-1:0] hostData,
	output logic [cpuIsaPkg::wordWidth-1:0] hostReadData
);
	import cpuIsaPkg::*;

	logic [wordWidth-1:0] ram [2 ** addrWidth];

	always_ff @(posedge clk) begin
		if (mem.write)
			ram[mem.address] <= mem.writeData;
		else if (hostWrite)
			ram[hostAddress] <= hostData;	// preload while idle
	end

	always_ff @(posedge clk) begin
		if (mem.read)
			mem.readData <= ram[mem.address];
		hostReadData <= ram[hostAddress];	// one cycle behind hostAddress
	end

	assert property (@(posedge clk) !(mem.write && hostWrite));

endmodule

/* hw/cpuTop.sv */
module cpuTop (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [cpuIsaPkg::wordWidth-1:0] startPc,
	input logic hostWrite,
	input logic [cpuIsaPkg::addrWidth-1:0] hostAddress,
	input logic [cpuIsaPkg::wordWidth-1:0] hostData,
	output logic [cpuIsaPkg::wordWidth-1:0] hostReadData,
	input logic [cpuIsaPkg::regIdxWidth-1:0] hostRegIndex,
	output logic [cpuIsaPkg::wordWidth-1:0] hostRegData,
	output logic busy,
	output logic done,
	output logic [cpuIsaPkg::wordWidth-1:0] pc
);
	import cpuIsaPkg::*;

	logic [regIdxWidth-1:0] regIndex;
	logic [wordWidth-1:0] regWriteData;
	logic [wordWidth-1:0] regReadData;
	logic regWrite;
	logic regBaOut;

	controlIf ctrlBus ();
	memoryIf memBus ();

	controlSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.ctrl(ctrlBus.sequencer),
		.busy(busy),
		.done(done)
	);

	registerFile registers (
		.clk(clk),
		.reset(reset),
		.index(regIndex),
		.writeData(regWriteData),
		.write(regWrite),
		.baOut(regBaOut),
		.readData(regReadData),
		.hostIndex(hostRegIndex),
		.hostData(hostRegData)
	);

	busDatapath datapath (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrlBus.datapath),
		.mem(memBus.master),
		.startPc(startPc),
		.start(start),
		.regIndex(regIndex),
		.regWriteData(regWriteData),
		.regWrite(regWrite),
		.regBaOut(regBaOut),
		.regReadData(regReadData),
		.pc(pc)
	);

	dataMemory ram (
		.clk(clk),
		.mem(memBus.memory),
		.hostWrite(hostWrite),
		.hostAddress(hostAddress),
		.hostData(hostData),
		.hostReadData(hostReadData)
	);

endmodule

/* verification/cpuTopTb.sv */
module cpuTopTb;
	timeunit 1ns;
	timeprecision 10ps;
	import cpuIsaPkg::*;

	logic clk;
	logic reset;
	logic start;
	logic [wordWidth-1:0] startPc;
	logic hostWrite;
	logic [addrWidth-1:0] hostAddress;
	logic [wordWidth-1:0] hostData;
	logic [wordWidth-1:0] hostReadData;
	logic [regIdxWidth-1:0] hostRegIndex;
	logic [wordWidth-1:0] hostRegData;
	logic busy;
	logic done;
	logic [wordWidth-1:0] pc;

	logic [31:0] stim [128];	// token stream from the data file
	logic [wordWidth-1:0] image [2 ** addrWidth];	// words the test put in memory
	int pos;	// read pointer into stim
	int limitCycles;

	cpuTop UUT (
		.clk(clk),
		.reset(reset),
		.start(start),
		.startPc(startPc),
		.hostWrite(hostWrite),
		.hostAddress(hostAddress),
		.hostData(hostData),
		.hostReadData(hostReadData),
		.hostRegIndex(hostRegIndex),
		.hostRegData(hostRegData),
		.busy(busy),
		.done(done),
		.pc(pc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("Timeout: the processor never finished within %0d cycles", limitCycles);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	function automatic logic [31:0] nextToken();
		nextToken = stim[pos];
		pos++;
	endfunction

	// walks the file once to size the watchdog
	function automatic int countLoadWords();
		int p;
		int n;
		int runs;
		int total;
		p = 1;
		total = 0;
		runs = stim[0];
		for (int r = 0; r < runs; r++) begin
			p = p + 1;	// skip start PC
			n = stim[p];
			total = total + n;
			p = p + 1 + 2 * n;
			n = stim[p];	// register checks
			p = p + 1 + 2 * n;
			n = stim[p];	// memory checks
			p = p + 1 + 2 * n;
		end
		return total;
	endfunction

	// straight-line code, so fetches run up to and including halt
	function automatic int countFetched(input logic [wordWidth-1:0] entry);
		for (int a = entry; a < 2 ** addrWidth; a++) begin
			if (image[a][opcodePos +: opcodeWidth] === opHalt)
				return a - entry + 1;
		end
		return 0;
	endfunction

	task automatic loadMemory();
		int count;
		logic [wordWidth-1:0] address;
		logic [wordWidth-1:0] value;
		count = nextToken();
		for (int i = 0; i < count; i++) begin
			address = nextToken();
			value = nextToken();
			image[address[addrWidth-1:0]] = value;
			@(posedge clk);
			hostWrite <= 1'b1;
			hostAddress <= address[addrWidth-1:0];
			hostData <= value;
		end
		@(posedge clk);
		hostWrite <= 1'b0;
	endtask

	task automatic runProgram(input logic [wordWidth-1:0] entry);
		int fetched;
		fetched = countFetched(entry);
		@(posedge clk);
		start <= 1'b1;
		startPc <= entry;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		checkValue("busy", busy, 1'b1);
		checkValue("done", done, 1'b0);
		while (!done) begin
			@(negedge clk);
		end
		checkValue("busy", busy, 1'b0);	// busy already low in the done cycle
		@(negedge clk);
		checkValue("done", done, 1'b0);	// single cycle pulse
		checkValue("busy", busy, 1'b0);
		checkValue("pc", pc, entry + fetched);
	endtask

	task automatic checkRegisters();
		int count;
		logic [wordWidth-1:0] index;
		logic [wordWidth-1:0] expected;
		count = nextToken();
		for (int i = 0; i < count; i++) begin
			index = nextToken();
			expected = nextToken();
			@(posedge clk);
			hostRegIndex <= index[regIdxWidth-1:0];
			@(negedge clk);
			checkValue($sformatf("r%0d", index), hostRegData, expected);
		end
	endtask

	task automatic checkMemory();
		int count;
		logic [wordWidth-1:0] address;
		logic [wordWidth-1:0] expected;
		count = nextToken();
		for (int i = 0; i < count; i++) begin
			address = nextToken();
			expected = nextToken();
			@(posedge clk);
			hostAddress <= address[addrWidth-1:0];
			@(posedge clk);	// registered read port
			@(negedge clk);
			checkValue($sformatf("mem[%h]", address[addrWidth-1:0]), hostReadData, expected);
		end
	endtask

	initial begin
		int runCount;
		logic [wordWidth-1:0] runPc;
		reset = 1'b1;
		start = 1'b0;
		startPc = '0;
		hostWrite = 1'b0;
		hostAddress = '0;
		hostData = '0;
		hostRegIndex = '0;
		pos = 0;
		$readmemh("verification/programInput.txt", stim);
		if ($isunknown(stim[0])) begin
			$display("Could not read stimulus from verification/programInput.txt");
			$display("TEST RESULT: FAIL");
			$fatal(1, "no stimulus");
		end
		limitCycles = countLoadWords() * 10 + 100;
		runCount = nextToken();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkValue("busy", busy, 1'b0);
		checkValue("done", done, 1'b0);
		checkValue("pc", pc, '0);
		for (int r = 0; r < runCount; r++) begin
			runPc = nextToken();
			loadMemory();
			runProgram(runPc);
			checkRegisters();
			checkMemory();
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* verification/programInput.txt */
// run count, then per run: start PC, load count, (address word) pairs,
// register check count, (index value) pairs, memory check count, (address value) pairs
2
// run 1 at 0x000
00000000
9
000 60800025 // addi r1, r0, 0x25
001 610FFFFD // addi r2, r1, -3
002 01800030 // ld r3, r0, 0x30
003 62180100 // addi r4, r3, 0x100
004 12100010 // st r4, r2, 0x10
005 0288000C // ld r5, r1, 0xC
006 D8000000 // halt
030 12345678
031 CAFEF00D
6
0 00000000
1 00000025
2 00000022
3 12345678
4 12345778
5 CAFEF00D
2
032 12345778
030 12345678
// run 2 at 0x040, registers kept from run 1
00000040
4
040 6307FFFE // addi r6, r0, -2
041 13080010 // st r6, r1, 0x10
042 03800035 // ld r7, r0, 0x35
043 D8000000 // halt
4
1 00000025
6 FFFFFFFE
7 FFFFFFFE
4 12345778
3
035 FFFFFFFE
032 12345778
031 CAFEF00D

/* all.f */
hw/cpuIsaPkg.sv
hw/cpuControlPkg.sv
hw/cpuInterfaces.sv
hw/controlSequencer.sv
hw/registerFile.sv
hw/busDatapath.sv
hw/dataMemory.sv
hw/cpuTop.sv
verification/cpuTopTb.sv
